// File: test/tri_mem_cases.txt
# L <128-bit MC word in hex: index {sid v2 v1 v0} or vertex {flag z y x}>, D ends a load
# R <id> <valid> <latency, 0 = any> <vertex0> <vertex1> <vertex2> <sid>, vertices {z y x} in hex
L 00000101000000020000000100000000
L 00000102000000030000000100000002
L 00000103000000050000000400000003
L 00000104000000070000000600000005
L 00000105000000040000040000000007
L 00000106000000000000000200000006
L 00000000000000000000000000000000
L 00000001300000002000000010000000
L 00000001300000012000000110000001
L 00000001300000022000000210000002
L 00000001300000032000000310000003
L 00000001300000042000000410000004
L 00000001300000052000000510000005
L 00000001300000062000000610000006
L 00000001300000072000000710000007
L 00000000000000000000000000000000
D
R 3 1 5 300000052000000510000005 300000062000000610000006 300000072000000710000007 00000104
R 4 1 1 300000072000000710000007 300000002000000010000000 300000042000000410000004 00000105
R 5 1 1 300000062000000610000006 300000022000000210000002 300000002000000010000000 00000106
R 1 1 5 300000022000000210000002 300000012000000110000001 300000032000000310000003 00000102
R 0 1 0 300000002000000010000000 300000012000000110000001 300000022000000210000002 00000101
R 2 1 0 300000032000000310000003 300000042000000410000004 300000052000000510000005 00000103
R 6 0 1 0 0 0 0
R 3 1 5 300000052000000510000005 300000062000000610000006 300000072000000710000007 00000104
R 200 0 1 0 0 0 0
R 511 0 1 0 0 0 0
R 1 1 5 300000022000000210000002 300000012000000110000001 300000032000000310000003 00000102
L 00000201000000010000000200000003
L 00000202000000020000000100000000
L 00000203000000000000000300000002
L 00000000000000000000000000000000
L 00000001600000005000000040000000
L 00000001600000015000000140000001
L 00000001600000025000000240000002
L 00000001600000035000000340000003
L 00000000000000000000000000000000
D
R 2 1 5 600000025000000240000002 600000035000000340000003 600000005000000040000000 00000203
R 0 1 5 600000035000000340000003 600000025000000240000002 600000015000000140000001 00000201
R 1 1 1 600000005000000040000000 600000015000000140000001 600000025000000240000002 00000202
R 2 1 1 600000025000000240000002 600000035000000340000003 600000005000000040000000 00000203
R 3 0 1 0 0 0 0
R 5 0 1 0 0 0 0

// File: all.f
+incdir+source
source/tri_mem_pkg.sv
source/tri_port_if.sv
source/scene_loader.sv
source/index_store.sv
source/vertex_store.sv
source/triangle_fetch.sv
source/tri_mem_top.sv
test/tri_mem_props.sv
test/tri_mem_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tri_mem_tb
FILELIST  ?= all.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
FAIL_MSG  ?= Simulation finished: FAIL
PASS_MSG  ?= Simulation finished: PASS

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)

run: compile
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG) || ! grep -q "$(PASS_MSG)" $(LOG); then \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	else \
		echo "simulation passed"; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: test/tri_mem_tb.sv
`timescale 1ns/1ps
`include "tri_mem_config.svh"

module tri_mem_tb;
    localparam int    CLK_PERIOD = 100;
    localparam int    READ_LIMIT = 12;
    // idle cycles that let a prefetch complete
    localparam int    HIT_GAP    = 6;
    localparam string CASE_FILE  = "test/tri_mem_cases.txt";

    logic                 clk;
    logic                 rst_n;
    logic                 we_mc;
    logic [127:0]         data_mc;
    logic                 rdy_mc;
    logic                 re_ic;
    logic [`TRI_ID_W-1:0] triangle_id;
    logic                 rdy_ic;
    logic                 not_valid_ic;
    tri_mem_pkg::vec3_t   vertex0;
    tri_mem_pkg::vec3_t   vertex1;
    tri_mem_pkg::vec3_t   vertex2;
    logic [31:0]          sid;

    string  cases[$];
    int     case_count;
    integer seed;
    int     errors;
    int     test_errors;
    int     tests_run;
    int     tests_failed;
    int     load_words;
    // strobe driven in the previous MC cycle
    logic   last_we;
    logic   loading;

    tri_mem_top u_dut (
        .clk          (clk),
        .rst_n        (rst_n),
        .we_mc        (we_mc),
        .data_mc      (data_mc),
        .rdy_mc       (rdy_mc),
        .re_ic        (re_ic),
        .triangle_id  (triangle_id),
        .rdy_ic       (rdy_ic),
        .not_valid_ic (not_valid_ic),
        .vertex0      (vertex0),
        .vertex1      (vertex1),
        .vertex2      (vertex2),
        .sid          (sid)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic report_mismatch(input string name, input logic [127:0] expected,
                                   input logic [127:0] actual);
        $display("mismatch at %0t: %s expected %h got %h", $time, name, expected, actual);
        test_errors++;
    endtask

    task automatic end_test(input string name);
        tests_run++;
        if (test_errors == 0) begin
            $display("test %0d %s: ok", tests_run, name);
        end else begin
            $display("test %0d %s: %0d errors", tests_run, name, test_errors);
            tests_failed++;
        end
        errors      = errors + test_errors;
        test_errors = 0;
    endtask

    // one MC cycle, ack must follow the previous strobe
    task automatic mc_cycle(input logic we, input logic [127:0] word);
        @(posedge clk);
        we_mc   <= we;
        data_mc <= word;
        @(negedge clk);
        if (rdy_mc !== last_we) begin
            report_mismatch("rdy_mc", last_we, rdy_mc);
        end
        last_we = we;
    endtask

    task automatic send_word(input logic [127:0] word);
        int gap;
        gap = $unsigned($random(seed)) % 3;
        repeat (gap) mc_cycle(1'b0, '0);
        mc_cycle(1'b1, word);
        load_words++;
    endtask

    task automatic finish_load();
        // ack of the last word, then load_busy has dropped
        mc_cycle(1'b0, '0);
        mc_cycle(1'b0, '0);
        end_test($sformatf("load of %0d words", load_words));
        load_words = 0;
        loading    = 1'b0;
    endtask

    task automatic read_triangle(input string line);
        int          id;
        int          valid;
        int          lat_exp;
        int          gap;
        int          lat;
        logic        answered;
        logic        exp_nv;
        logic [95:0] exp_v0;
        logic [95:0] exp_v1;
        logic [95:0] exp_v2;
        logic [31:0] exp_sid;

        if ($sscanf(line.substr(2, line.len() - 1), "%d %d %d %h %h %h %h",
                    id, valid, lat_exp, exp_v0, exp_v1, exp_v2, exp_sid) != 7) begin
            $display("error: read case could not be parsed: %s", line);
            test_errors++;
            end_test("read case");
            return;
        end
        exp_nv = (valid == 0);
        gap    = $unsigned($random(seed)) % 2;
        if (lat_exp == 1) begin
            gap = gap + HIT_GAP;
        end
        repeat (gap) @(posedge clk);
        @(posedge clk);
        re_ic       <= 1'b1;
        triangle_id <= id[`TRI_ID_W-1:0];
        lat      = 0;
        answered = 1'b0;
        while (!answered && lat < READ_LIMIT) begin
            @(posedge clk);
            re_ic <= 1'b0;
            lat++;
            @(negedge clk);
            answered = rdy_ic || not_valid_ic;
        end
        if (!answered) begin
            $display("error: no rdy_ic or not_valid_ic within %0d cycles for id %0d",
                     READ_LIMIT, id);
            test_errors++;
        end else begin
            if (not_valid_ic !== exp_nv) begin
                report_mismatch("not_valid_ic", exp_nv, not_valid_ic);
            end
            if (rdy_ic !== !exp_nv) begin
                report_mismatch("rdy_ic", !exp_nv, rdy_ic);
            end
            if (lat_exp != 0 && lat != lat_exp) begin
                report_mismatch("response latency", lat_exp, lat);
            end
            if (!exp_nv) begin
                if (vertex0 !== exp_v0) begin
                    report_mismatch("vertex0", exp_v0, vertex0);
                end
                if (vertex1 !== exp_v1) begin
                    report_mismatch("vertex1", exp_v1, vertex1);
                end
                if (vertex2 !== exp_v2) begin
                    report_mismatch("vertex2", exp_v2, vertex2);
                end
                if (sid !== exp_sid) begin
                    report_mismatch("sid", exp_sid, sid);
                end
            end
        end
        end_test($sformatf("read id %0d", id));
    endtask

    initial begin
        int           fd;
        string        line;
        logic [127:0] word;

        clk          = 1'b0;
        rst_n        = 1'b0;
        we_mc        = 1'b0;
        data_mc      = '0;
        re_ic        = 1'b0;
        triangle_id  = '0;
        seed         = 32'haa2ef899;
        errors       = 0;
        test_errors  = 0;
        tests_run    = 0;
        tests_failed = 0;
        load_words   = 0;
        last_we      = 1'b0;
        loading      = 1'b0;

        fd = $fopen(CASE_FILE, "r");
        if (fd == 0) begin
            $display("error: case file %s could not be opened", CASE_FILE);
            errors++;
        end else begin
            while (!$feof(fd)) begin
                line = "";
                if ($fgets(line, fd) > 0 && line.len() > 0) begin
                    if (line.getc(0) == "L" || line.getc(0) == "R" || line.getc(0) == "D") begin
                        cases.push_back(line);
                    end
                end
            end
            $fclose(fd);
        end
        case_count = cases.size();

        repeat (5) @(posedge clk);
        rst_n <= 1'b1;

        foreach (cases[i]) begin
            case (cases[i].getc(0))
                "L": begin
                    // let any running prefetch settle before a new scene
                    if (!loading) begin
                        repeat (HIT_GAP) @(posedge clk);
                        loading = 1'b1;
                    end
                    if ($sscanf(cases[i].substr(2, cases[i].len() - 1), "%h", word) == 1) begin
                        send_word(word);
                    end else begin
                        $display("error: load word could not be parsed: %s", cases[i]);
                        test_errors++;
                    end
                end
                "D": finish_load();
                default: read_triangle(cases[i]);
            endcase
        end

        repeat (2) @(posedge clk);
        $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0 && tests_run > 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

    // worst case of about 20 cycles per case line
    initial begin
        int limit;
        wait (case_count > 0);
        limit = case_count * 20 + 20;
        repeat (limit) @(posedge clk);
        $display("error: run did not finish within %0d cycles", limit);
        $display("Simulation finished: FAIL");
        $finish;
    end

endmodule

// File: test/tri_mem_props.sv
`timescale 1ns/1ps

module tri_mem_props (
    input logic clk,
    input logic rst_n,
    input logic re_ic,
    input logic load_busy,
    input logic rdy_ic,
    input logic not_valid_ic
);
    // high from a request until its answer
    logic req_open;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            req_open <= 1'b0;
        end else if (re_ic) begin
            req_open <= 1'b1;
        end else if (rdy_ic || not_valid_ic) begin
            req_open <= 1'b0;
        end
    end

    answer_exclusive: assert property (
        @(posedge clk) disable iff (!rst_n) !(rdy_ic && not_valid_ic)
    ) else $error("rdy_ic and not_valid_ic high together");

    one_open_request: assert property (
        @(posedge clk) disable iff (!rst_n) re_ic |-> !req_open
    ) else $error("re_ic issued while a request is open");

    no_read_in_load: assert property (
        @(posedge clk) disable iff (!rst_n) re_ic |-> !load_busy
    ) else $error("re_ic issued during a scene load");

endmodule

bind triangle_fetch tri_mem_props u_props (
    .clk          (clk),
    .rst_n        (rst_n),
    .re_ic        (re_ic),
    .load_busy    (load_busy),
    .rdy_ic       (rdy_ic),
    .not_valid_ic (not_valid_ic)
);

// File: source/tri_mem_top.sv
`timescale 1ns/1ps
`include "tri_mem_config.svh"

module tri_mem_top (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 we_mc,
    input  logic [127:0]         data_mc,
    output logic                 rdy_mc,
    input  logic                 re_ic,
    input  logic [`TRI_ID_W-1:0] triangle_id,
    output logic                 rdy_ic,
    output logic                 not_valid_ic,
    output tri_mem_pkg::vec3_t   vertex0,
    output tri_mem_pkg::vec3_t   vertex1,
    output tri_mem_pkg::vec3_t   vertex2,
    output logic [31:0]          sid
);
    localparam int IDX_W = $bits(tri_mem_pkg::index_rec_t);
    localparam int VTX_W = $bits(tri_mem_pkg::vec3_t);

    logic [`TRI_ID_W:0] tri_count;
    logic               load_busy;

    tri_port_if #(.ADDR_W(`TRI_ID_W), .DATA_W(IDX_W)) idx_wr ();
    tri_port_if #(.ADDR_W(`TRI_ID_W), .DATA_W(IDX_W)) idx_rd ();
    tri_port_if #(.ADDR_W(`VTX_ID_W), .DATA_W(VTX_W)) vtx_wr ();
    tri_port_if #(.ADDR_W(`VTX_ID_W), .DATA_W(VTX_W)) vtx_rd ();

    scene_loader u_loader (
        .clk       (clk),
        .rst_n     (rst_n),
        .we_mc     (we_mc),
        .data_mc   (data_mc),
        .rdy_mc    (rdy_mc),
        .idx_wr    (idx_wr.requester),
        .vtx_wr    (vtx_wr.requester),
        .tri_count (tri_count),
        .load_busy (load_busy)
    );

    index_store u_index (
        .clk       (clk),
        .rst_n     (rst_n),
        .load_busy (load_busy),
        .wr_port   (idx_wr.memory),
        .rd_port   (idx_rd.memory)
    );

    vertex_store u_vertex (
        .clk       (clk),
        .rst_n     (rst_n),
        .load_busy (load_busy),
        .wr_port   (vtx_wr.memory),
        .rd_port   (vtx_rd.memory)
    );

    triangle_fetch u_fetch (
        .clk          (clk),
        .rst_n        (rst_n),
        .re_ic        (re_ic),
        .triangle_id  (triangle_id),
        .tri_count    (tri_count),
        .load_busy    (load_busy),
        .idx_rd       (idx_rd.requester),
        .vtx_rd       (vtx_rd.requester),
        .rdy_ic       (rdy_ic),
        .not_valid_ic (not_valid_ic),
        .vertex0      (vertex0),
        .vertex1      (vertex1),
        .vertex2      (vertex2),
        .sid          (sid)
    );

endmodule

// File: source/triangle_fetch.sv
`timescale 1ns/1ps
`include "tri_mem_config.svh"

module triangle_fetch (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 re_ic,
    input  logic [`TRI_ID_W-1:0] triangle_id,
    input  logic [`TRI_ID_W:0]   tri_count,
    input  logic                 load_busy,
    tri_port_if.requester        idx_rd,
    tri_port_if.requester        vtx_rd,
    output logic                 rdy_ic,
    output logic                 not_valid_ic,
    output tri_mem_pkg::vec3_t   vertex0,
    output tri_mem_pkg::vec3_t   vertex1,
    output tri_mem_pkg::vec3_t   vertex2,
    output logic [31:0]          sid
);
    typedef enum logic [2:0] {S_IDLE, S_V0, S_V1, S_V2, S_FIN} state_t;

    state_t                  state;
    state_t                  state_nx;
    // id of the triangle being fetched, or of the finished prefetch
    logic [`TRI_ID_W-1:0]    cur_id;
    logic [`TRI_ID_W-1:0]    cur_id_nx;
    logic [`TRI_ID_W-1:0]    next_id;
    // sequence answers an open request
    logic                    dem;
    logic                    dem_nx;
    logic                    pf_valid;
    logic                    pf_valid_nx;
    logic                    id_bad;
    logic                    next_ok;
    logic                    cur_hit;
    logic                    out_ld;
    logic                    out_fin;
    logic                    rdy_d;
    logic                    nv_d;
    tri_mem_pkg::index_rec_t rec_now;
    tri_mem_pkg::index_rec_t rec_q;
    // shadow buffers
    tri_mem_pkg::vec3_t      b0;
    tri_mem_pkg::vec3_t      b1;
    tri_mem_pkg::vec3_t      b2;
    logic [31:0]             bsid;

    assign rec_now = idx_rd.rdata;
    assign next_id = cur_id + 1'b1;
    assign next_ok = ({1'b0, cur_id} + 1'b1) < tri_count;
    assign id_bad  = {1'b0, triangle_id} >= tri_count;
    assign cur_hit = triangle_id == cur_id;

    assign idx_rd.we    = 1'b0;
    assign idx_rd.wdata = '0;
    assign vtx_rd.we    = 1'b0;
    assign vtx_rd.wdata = '0;

    always_comb begin
        state_nx    = state;
        cur_id_nx   = cur_id;
        dem_nx      = dem;
        pf_valid_nx = pf_valid;
        idx_rd.en   = 1'b0;
        idx_rd.addr = next_id;
        vtx_rd.en   = 1'b0;
        vtx_rd.addr = rec_now.v0[`VTX_ID_W-1:0];
        out_ld      = 1'b0;
        out_fin     = 1'b0;
        rdy_d       = 1'b0;
        nv_d        = 1'b0;
        if (load_busy) begin
            // a new scene makes any prefetch stale
            state_nx    = S_IDLE;
            pf_valid_nx = 1'b0;
        end else if (re_ic && id_bad) begin
            nv_d        = 1'b1;
            state_nx    = S_IDLE;
            pf_valid_nx = 1'b0;
        end else if (re_ic && state == S_IDLE && pf_valid && cur_hit) begin
            // hit, answer from shadow and prefetch the next id
            out_ld      = 1'b1;
            rdy_d       = 1'b1;
            pf_valid_nx = 1'b0;
            if (next_ok) begin
                idx_rd.en = 1'b1;
                cur_id_nx = next_id;
                dem_nx    = 1'b0;
                state_nx  = S_V0;
            end
        end else if (re_ic && (state == S_IDLE || !cur_hit)) begin
            // miss, or a request that differs from the prefetch in flight
            idx_rd.en   = 1'b1;
            idx_rd.addr = triangle_id;
            cur_id_nx   = triangle_id;
            dem_nx      = 1'b1;
            pf_valid_nx = 1'b0;
            state_nx    = S_V0;
        end else begin
            // request matching the prefetch in flight takes it over
            if (re_ic) begin
                dem_nx = 1'b1;
            end
            case (state)
                S_V0: begin
                    vtx_rd.en = 1'b1;
                    // overlap the next record while vertices are read
                    idx_rd.en = next_ok;
                    state_nx  = S_V1;
                end
                S_V1: begin
                    vtx_rd.en   = 1'b1;
                    vtx_rd.addr = rec_q.v1[`VTX_ID_W-1:0];
                    state_nx    = S_V2;
                end
                S_V2: begin
                    vtx_rd.en   = 1'b1;
                    vtx_rd.addr = rec_q.v2[`VTX_ID_W-1:0];
                    state_nx    = S_FIN;
                end
                S_FIN: begin
                    if (dem_nx) begin
                        out_ld  = 1'b1;
                        out_fin = 1'b1;
                        rdy_d   = 1'b1;
                    end else begin
                        pf_valid_nx = 1'b1;
                    end
                    // next record already sits in the index store output
                    if (dem_nx && next_ok) begin
                        cur_id_nx = next_id;
                        dem_nx    = 1'b0;
                        state_nx  = S_V0;
                    end else begin
                        state_nx = S_IDLE;
                    end
                end
                default: ;
            endcase
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state        <= S_IDLE;
            cur_id       <= '0;
            dem          <= 1'b0;
            pf_valid     <= 1'b0;
            rdy_ic       <= 1'b0;
            not_valid_ic <= 1'b0;
            vertex0      <= '0;
            vertex1      <= '0;
            vertex2      <= '0;
            sid          <= '0;
        end else begin
            state        <= state_nx;
            cur_id       <= cur_id_nx;
            dem          <= dem_nx;
            pf_valid     <= pf_valid_nx;
            rdy_ic       <= rdy_d;
            not_valid_ic <= nv_d;
            if (out_ld) begin
                vertex0 <= b0;
                vertex1 <= b1;
                vertex2 <= out_fin ? tri_mem_pkg::vec3_t'(vtx_rd.rdata) : b2;
                sid     <= out_fin ? rec_q.sid : bsid;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (state == S_V0) begin
            rec_q <= rec_now;
        end
        if (state == S_V1) begin
            b0 <= vtx_rd.rdata;
        end
        if (state == S_V2) begin
            b1 <= vtx_rd.rdata;
        end
        if (state == S_FIN) begin
            b2   <= vtx_rd.rdata;
            bsid <= rec_q.sid;
        end
    end

endmodule

// File: source/vertex_store.sv
`timescale 1ns/1ps
`include "tri_mem_config.svh"

module vertex_store (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       load_busy,
    tri_port_if.memory wr_port,
    tri_port_if.memory rd_port
);
    tri_mem_pkg::vec3_t   mem [`VTX_NUM];
    tri_mem_pkg::vec3_t   rd_q;
    tri_mem_pkg::vec3_t   wdata;
    logic                 en;
    logic                 we;
    logic [`VTX_ID_W-1:0] addr;

    assign en    = load_busy ? wr_port.en    : rd_port.en;
    assign we    = load_busy ? wr_port.we    : rd_port.we;
    assign addr  = load_busy ? wr_port.addr  : rd_port.addr;
    assign wdata = load_busy ? wr_port.wdata : rd_port.wdata;

    always_ff @(posedge clk) begin
        if (en && we) begin
            mem[addr] <= wdata;
        end
    end

    // one vertex per cycle for the fetch sequencer
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_q <= '0;
        end else if (en && !we) begin
            rd_q <= mem[addr];
        end
    end

    assign wr_port.rdata = rd_q;
    assign rd_port.rdata = rd_q;

endmodule

// File: source/index_store.sv
`timescale 1ns/1ps
`include "tri_mem_config.svh"

module index_store (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       load_busy,
    tri_port_if.memory wr_port,
    tri_port_if.memory rd_port
);
    localparam int VW     = `VTX_ID_W;
    // sid plus three trimmed vertex indices
    localparam int SLOT_W = 32 + 3 * VW;

    logic [SLOT_W-1:0]       mem [`TRI_NUM];
    logic [SLOT_W-1:0]       slot_q;
    logic                    en;
    logic                    we;
    logic [`TRI_ID_W-1:0]    addr;
    tri_mem_pkg::index_rec_t wrec;
    tri_mem_pkg::index_rec_t rrec;

    // loader owns the port for the whole load
    assign en   = load_busy ? wr_port.en    : rd_port.en;
    assign we   = load_busy ? wr_port.we    : rd_port.we;
    assign addr = load_busy ? wr_port.addr  : rd_port.addr;
    assign wrec = load_busy ? wr_port.wdata : rd_port.wdata;

    always_ff @(posedge clk) begin
        if (en && we) begin
            mem[addr] <= {wrec.sid, wrec.v2[VW-1:0], wrec.v1[VW-1:0], wrec.v0[VW-1:0]};
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            slot_q <= '0;
        end else if (en && !we) begin
            slot_q <= mem[addr];
        end
    end

    // widen indices back to the record layout
    assign rrec.sid = slot_q[SLOT_W-1 -: 32];
    assign rrec.v2  = 32'(slot_q[3*VW-1 -: VW]);
    assign rrec.v1  = 32'(slot_q[2*VW-1 -: VW]);
    assign rrec.v0  = 32'(slot_q[VW-1:0]);

    assign wr_port.rdata = rrec;
    assign rd_port.rdata = rrec;

endmodule

// File: source/scene_loader.sv
`timescale 1ns/1ps
`include "tri_mem_config.svh"

module scene_loader (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  we_mc,
    input  tri_mem_pkg::mc_word_u data_mc,
    output logic                  rdy_mc,
    tri_port_if.requester         idx_wr,
    tri_port_if.requester         vtx_wr,
    output logic [`TRI_ID_W:0]    tri_count,
    output logic                  load_busy
);
    // set once the zero-sid word has been seen
    logic                 vtx_phase;
    logic [`TRI_ID_W:0]   idx_cnt;
    logic [`VTX_ID_W-1:0] vtx_cnt;
    logic                 idx_word;
    logic                 vtx_word;
    logic                 idx_last;
    logic                 vtx_last;
    logic                 idx_wr_q;
    logic                 vtx_wr_q;

    assign idx_word = we_mc && !vtx_phase;
    assign vtx_word = we_mc && vtx_phase;
    assign idx_last = data_mc.idx.sid == '0;
    assign vtx_last = data_mc.vtx.flag == '0;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rdy_mc    <= 1'b0;
            load_busy <= 1'b0;
            vtx_phase <= 1'b0;
            idx_cnt   <= '0;
            vtx_cnt   <= '0;
            tri_count <= '0;
            idx_wr_q  <= 1'b0;
            vtx_wr_q  <= 1'b0;
        end else begin
            // acknowledge only, every word is taken
            rdy_mc   <= we_mc;
            idx_wr_q <= idx_word && !idx_last;
            vtx_wr_q <= vtx_word && !vtx_last;
            if (we_mc) begin
                load_busy <= !(vtx_word && vtx_last);
            end
            if (idx_word) begin
                if (idx_last) begin
                    tri_count <= idx_cnt;
                    vtx_phase <= 1'b1;
                    vtx_cnt   <= '0;
                end else begin
                    idx_cnt <= idx_cnt + 1'b1;
                end
            end
            if (vtx_word) begin
                if (vtx_last) begin
                    vtx_phase <= 1'b0;
                    idx_cnt   <= '0;
                end else begin
                    vtx_cnt <= vtx_cnt + 1'b1;
                end
            end
        end
    end

    // write requests go out one cycle after the strobe
    always_ff @(posedge clk) begin
        if (idx_word) begin
            idx_wr.addr  <= idx_cnt[`TRI_ID_W-1:0];
            idx_wr.wdata <= data_mc.idx;
        end
        if (vtx_word) begin
            vtx_wr.addr  <= vtx_cnt;
            vtx_wr.wdata <= {data_mc.vtx.z, data_mc.vtx.y, data_mc.vtx.x};
        end
    end

    assign idx_wr.en = idx_wr_q;
    assign idx_wr.we = 1'b1;
    assign vtx_wr.en = vtx_wr_q;
    assign vtx_wr.we = 1'b1;

endmodule

// File: source/tri_port_if.sv
`timescale 1ns/1ps

// single-port memory request bundle
interface tri_port_if #(
    parameter int ADDR_W = 9,
    parameter int DATA_W = 128
);
    logic              en;
    logic              we;
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] wdata;
    // valid the cycle after a read request
    logic [DATA_W-1:0] rdata;

    modport requester (
        output en, we, addr, wdata,
        input  rdata
    );

    modport memory (
        input  en, we, addr, wdata,
        output rdata
    );
endinterface

// File: source/tri_mem_pkg.sv
`include "tri_mem_config.svh"

package tri_mem_pkg;

    // index phase word, one triangle
    typedef struct packed {
        logic [31:0] sid;
        logic [31:0] v2;
        logic [31:0] v1;
        logic [31:0] v0;
    } index_rec_t;

    // vertex phase word, zero flag ends the load
    typedef struct packed {
        logic [`COORD_W-1:0] flag;
        logic [`COORD_W-1:0] z;
        logic [`COORD_W-1:0] y;
        logic [`COORD_W-1:0] x;
    } vertex_rec_t;

    // stored and returned vertex
    typedef struct packed {
        logic [`COORD_W-1:0] z;
        logic [`COORD_W-1:0] y;
        logic [`COORD_W-1:0] x;
    } vec3_t;

    // meaning of an MC word depends on the load phase
    typedef union packed {
        index_rec_t  idx;
        vertex_rec_t vtx;
    } mc_word_u;

endpackage

// File: source/tri_mem_config.svh
`ifndef TRI_MEM_CONFIG_SVH
`define TRI_MEM_CONFIG_SVH

// scene capacity
`define TRI_NUM 512
`define VTX_NUM 1024

// id widths follow the memory depths
`define TRI_ID_W ($clog2(`TRI_NUM))
`define VTX_ID_W ($clog2(`VTX_NUM))

// one single-precision coordinate
`define COORD_W 32

`endif
